// ==== source/blob_track_pkg.sv ====
package blob_track_pkg;

	localparam int NUM_SLOTS = 6; // Centroid slots in the result
	localparam logic [7:0] MAX_HEIGHT = 8'd120;

	typedef logic [15:0] key_t;
	typedef logic [15:0] rec_idx_t;

	typedef enum logic {
		KEY_SIZE,
		KEY_HEIGHT
	} key_mode_e;

	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
		logic [15:0] size; // Pixel count
	} centroid_t;

	typedef struct packed {
		logic [23:0] rsvd;
		logic [7:0] code; // Zero means no recognized color
	} color_rec_t;

	// Centroid and key words use the centroid view, color words the other
	typedef union packed {
		centroid_t centroid;
		color_rec_t color_rec;
	} blob_word_u;

	typedef struct packed {
		logic clear;
		logic take_color;
		logic take_key;
		logic fetch;
	} track_ctrl_t;

	typedef struct packed {
		centroid_t [NUM_SLOTS-1:0] blob;
	} track_result_t;

endpackage

// ==== source/track_mem_pkg.sv ====
package track_mem_pkg;

	typedef logic [17:0] addr_t;

	localparam addr_t RECORD_BASE = 18'd200000; // Record 0
	localparam addr_t RECORD_STRIDE = 18'd3;

	localparam addr_t CENTROID_OFS = 18'd0;
	localparam addr_t COLOR_OFS = 18'd1;
	localparam addr_t KEY_OFS = 18'd2;

	// Word address of one field of a record
	function automatic addr_t record_addr(input addr_t idx, input addr_t ofs);
		return RECORD_BASE + idx * RECORD_STRIDE + ofs;
	endfunction

endpackage

// ==== source/track_fsm.sv ====
`timescale 1ns/1ps

module track_fsm
	import blob_track_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic pause,
	input logic enable,
	input blob_word_u mem_data,
	input logic scan_end,
	input logic slot_end,
	output track_ctrl_t ctrl,
	output logic done
);

	typedef enum logic [2:0] {
		IDLE,
		CLEAR,
		SCAN_COLOR,
		SCAN_KEY,
		FETCH,
		DONE
	} state_e;

	state_e state;
	state_e state_nxt;
	logic [1:0] en_cnt;
	logic [1:0] en_cnt_nxt;
	logic fetch_cap; // Second cycle of a fetch slot
	logic color_nz;

	assign color_nz = (mem_data.color_rec.code != 8'd0);

	// Enable must be seen on two consecutive cycles
	assign en_cnt_nxt = !enable ? 2'd0 : (en_cnt == 2'd2) ? 2'd2 : en_cnt + 2'd1;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: if (en_cnt_nxt == 2'd2) state_nxt = CLEAR;
			CLEAR: state_nxt = SCAN_COLOR;
			SCAN_COLOR: begin
				if (scan_end)
					state_nxt = FETCH;
				else if (color_nz)
					state_nxt = SCAN_KEY; // Key word follows
			end
			SCAN_KEY: state_nxt = SCAN_COLOR;
			FETCH: if (fetch_cap && slot_end) state_nxt = DONE;
			DONE: state_nxt = DONE;
			default: state_nxt = IDLE;
		endcase
		if (!enable)
			state_nxt = IDLE;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			en_cnt <= 2'd0;
			fetch_cap <= 1'b0;
		end else if (!pause) begin
			state <= state_nxt;
			en_cnt <= en_cnt_nxt;
			fetch_cap <= (state == FETCH) && (state_nxt == FETCH) && !fetch_cap;
		end
	end

	always_comb begin
		ctrl.clear = (state == CLEAR);
		ctrl.take_color = (state == SCAN_COLOR) && !scan_end && color_nz;
		ctrl.take_key = (state == SCAN_KEY);
		ctrl.fetch = (state == FETCH) && !fetch_cap; // Issue cycle only
	end

	assign done = (state == DONE);

endmodule

// ==== source/record_counter.sv ====
`timescale 1ns/1ps

module record_counter
	import blob_track_pkg::*, track_mem_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic pause,
	input track_ctrl_t ctrl,
	input rec_idx_t blob_count,
	input addr_t fetch_addr,
	output addr_t mem_addr,
	output rec_idx_t rec_idx,
	output logic scan_end,
	output logic [2:0] slot,
	output logic slot_end
);

	logic scan_act; // Set from clear until the record count is reached
	rec_idx_t next_idx;

	assign next_idx = rec_idx + 16'd1;
	assign scan_end = (rec_idx == blob_count);
	assign slot_end = (slot == 3'(NUM_SLOTS));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rec_idx <= '0;
			slot <= '0;
			scan_act <= 1'b0;
		end else if (!pause) begin
			if (ctrl.clear) begin
				rec_idx <= '0;
				slot <= '0;
				scan_act <= 1'b1;
			end else begin
				if (scan_act) begin
					if (scan_end)
						scan_act <= 1'b0;
					else if (!ctrl.take_color)
						rec_idx <= next_idx; // Hold while the key word is read
				end
				if (ctrl.fetch)
					slot <= slot + 3'd1;
			end
		end
	end

	// Address for the word returned on the next cycle
	always_comb begin
		if (ctrl.fetch)
			mem_addr = fetch_addr;
		else if (ctrl.clear)
			mem_addr = record_addr('0, COLOR_OFS);
		else if (scan_act && ctrl.take_color)
			mem_addr = record_addr(addr_t'(rec_idx), KEY_OFS);
		else if (scan_act)
			mem_addr = record_addr(addr_t'(next_idx), COLOR_OFS);
		else
			mem_addr = '0;
	end

endmodule

// ==== source/rank_table.sv ====
`timescale 1ns/1ps

module rank_table
	import blob_track_pkg::*;
#(
	parameter int NUM_COLORS = 6,
	parameter int NUM_RANKS = 3
) (
	input logic clk,
	input logic rst_n,
	input logic pause,
	input track_ctrl_t ctrl,
	input blob_word_u mem_data,
	input rec_idx_t rec_idx,
	input key_mode_e key_mode,
	input logic [7:0] min_size,
	input logic [$clog2(NUM_COLORS*NUM_RANKS)-1:0] rd_entry,
	output key_t rd_key,
	output rec_idx_t rd_rec
);

	localparam int NUM_ENTRIES = NUM_COLORS * NUM_RANKS;
	localparam int CW = $clog2(NUM_COLORS);

	// Entry index is rank * NUM_COLORS + color
	key_t tbl_key [NUM_ENTRIES];
	rec_idx_t tbl_rec [NUM_ENTRIES];

	logic [CW-1:0] cur_col;
	logic col_ok; // Color code within range
	key_t new_key;
	key_t ins_key [NUM_RANKS];
	rec_idx_t ins_rec [NUM_RANKS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cur_col <= '0;
			col_ok <= 1'b0;
		end else if (!pause && ctrl.take_color) begin
			col_ok <= (mem_data.color_rec.code <= 8'(NUM_COLORS));
			if (mem_data.color_rec.code <= 8'(NUM_COLORS))
				cur_col <= CW'(mem_data.color_rec.code - 8'd1); // Stored offset by one
		end
	end

	always_comb begin
		if (key_mode == KEY_HEIGHT)
			new_key = (mem_data.centroid.y > MAX_HEIGHT) ? '0 : key_t'(mem_data.centroid.y);
		else
			new_key = mem_data.centroid.size;
	end

	// New row for the current color, entries below the insertion point move down
	always_comb begin
		key_t carry_key;
		rec_idx_t carry_rec;
		logic shifting;
		int e;
		carry_key = '0;
		carry_rec = '0;
		shifting = 1'b0;
		for (int r = 0; r < NUM_RANKS; r++) begin
			e = r * NUM_COLORS + int'(cur_col);
			ins_key[r] = tbl_key[e];
			ins_rec[r] = tbl_rec[e];
			if (shifting) begin
				ins_key[r] = carry_key;
				ins_rec[r] = carry_rec;
			end else if (new_key > key_t'(min_size) && new_key > tbl_key[e]) begin
				ins_key[r] = new_key;
				ins_rec[r] = rec_idx;
				shifting = 1'b1;
			end
			carry_key = tbl_key[e];
			carry_rec = tbl_rec[e];
		end
	end

	always_ff @(posedge clk) begin
		if (!pause) begin
			if (ctrl.clear) begin
				for (int i = 0; i < NUM_ENTRIES; i++) begin
					tbl_key[i] <= '0;
					tbl_rec[i] <= '0;
				end
			end else if (ctrl.take_key && col_ok) begin
				for (int r = 0; r < NUM_RANKS; r++) begin
					tbl_key[r * NUM_COLORS + int'(cur_col)] <= ins_key[r];
					tbl_rec[r * NUM_COLORS + int'(cur_col)] <= ins_rec[r];
				end
			end
		end
	end

	assign rd_key = tbl_key[rd_entry];
	assign rd_rec = tbl_rec[rd_entry];

endmodule

// ==== source/centroid_collector.sv ====
`timescale 1ns/1ps

module centroid_collector
	import blob_track_pkg::*, track_mem_pkg::*;
#(
	parameter int NUM_COLORS = 6,
	parameter int NUM_RANKS = 3
) (
	input logic clk,
	input logic rst_n,
	input logic pause,
	input track_ctrl_t ctrl,
	input logic two_color,
	input logic [2:0] slot,
	input blob_word_u mem_data,
	input key_t rd_key,
	input rec_idx_t rd_rec,
	output logic [$clog2(NUM_COLORS*NUM_RANKS)-1:0] rd_entry,
	output addr_t fetch_addr,
	output track_result_t result
);

	localparam int EW = $clog2(NUM_COLORS * NUM_RANKS);

	int unsigned ent_rank;
	int unsigned ent_color;
	logic cap_en; // Capture on this cycle
	logic [2:0] cap_slot;

	// Slot to table entry
	always_comb begin
		if (two_color) begin
			if (int'(slot) < NUM_RANKS) begin
				ent_rank = int'(slot);
				ent_color = 0;
			end else begin
				ent_rank = int'(slot) - NUM_RANKS;
				ent_color = 1; // Second color fills the upper slots
			end
		end else begin
			ent_rank = 0; // Best blob of each color
			ent_color = int'(slot);
		end
		rd_entry = EW'(ent_rank * NUM_COLORS + ent_color);
	end

	assign fetch_addr = record_addr(addr_t'(rd_rec), CENTROID_OFS);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cap_en <= 1'b0;
			cap_slot <= '0;
			result <= '0;
		end else if (!pause) begin
			cap_en <= ctrl.fetch && (rd_key != '0); // Empty entries leave the slot zero
			if (ctrl.fetch)
				cap_slot <= slot;
			if (ctrl.clear)
				result <= '0;
			else if (cap_en)
				result.blob[cap_slot] <= mem_data.centroid;
		end
	end

endmodule

// ==== source/blob_tracker.sv ====
`timescale 1ns/1ps

module blob_tracker
	import blob_track_pkg::*, track_mem_pkg::*;
#(
	parameter int NUM_COLORS = 6,
	parameter int NUM_RANKS = 3
) (
	input logic clk,
	input logic rst_n,
	input logic pause,
	input logic enable,
	input rec_idx_t blob_count,
	input key_mode_e key_mode,
	input logic [7:0] min_size,
	input logic two_color,
	input blob_word_u mem_data,
	output addr_t mem_addr,
	output track_result_t result,
	output logic done
);

	localparam int ENTRY_W = $clog2(NUM_COLORS * NUM_RANKS);

	track_ctrl_t ctrl;
	logic scan_end;
	logic slot_end;
	logic [2:0] slot;
	rec_idx_t rec_idx;
	addr_t fetch_addr;
	logic [ENTRY_W-1:0] rd_entry;
	key_t rd_key;
	rec_idx_t rd_rec;

	track_fsm u_fsm (
		.clk(clk), .rst_n(rst_n), .pause(pause), .enable(enable),
		.mem_data(mem_data), .scan_end(scan_end), .slot_end(slot_end),
		.ctrl(ctrl), .done(done)
	);

	record_counter u_counter (
		.clk(clk), .rst_n(rst_n), .pause(pause), .ctrl(ctrl),
		.blob_count(blob_count), .fetch_addr(fetch_addr), .mem_addr(mem_addr),
		.rec_idx(rec_idx), .scan_end(scan_end), .slot(slot), .slot_end(slot_end)
	);

	rank_table #(.NUM_COLORS(NUM_COLORS), .NUM_RANKS(NUM_RANKS)) u_table (
		.clk(clk), .rst_n(rst_n), .pause(pause), .ctrl(ctrl), .mem_data(mem_data),
		.rec_idx(rec_idx), .key_mode(key_mode), .min_size(min_size),
		.rd_entry(rd_entry), .rd_key(rd_key), .rd_rec(rd_rec)
	);

	centroid_collector #(.NUM_COLORS(NUM_COLORS), .NUM_RANKS(NUM_RANKS)) u_collect (
		.clk(clk), .rst_n(rst_n), .pause(pause), .ctrl(ctrl), .two_color(two_color),
		.slot(slot), .mem_data(mem_data), .rd_key(rd_key), .rd_rec(rd_rec),
		.rd_entry(rd_entry), .fetch_addr(fetch_addr), .result(result)
	);

endmodule

// ==== include/tb_blob_model.svh ====
`ifndef TB_BLOB_MODEL_SVH
`define TB_BLOB_MODEL_SVH

// Random records with color codes in lo..hi, narrow key ranges make ties likely
task automatic load_records(input int n, input int lo, input int hi);
	addr_t base;
	for (int i = 0; i < n; i++) begin
		base = RECORD_BASE + addr_t'(i) * RECORD_STRIDE;
		rec_cen[i] = {8'(i), 8'($urandom), 16'($urandom)}; // x is the record index
		rec_code[i] = 8'($urandom_range(hi, lo));
		rec_key[i] = {8'($urandom), 8'($urandom), 16'($urandom_range(60))};
		mem[base + CENTROID_OFS] = rec_cen[i];
		mem[base + COLOR_OFS] = {24'h0, rec_code[i]};
		mem[base + KEY_OFS] = rec_key[i];
	end
endtask

// Top three keys per color in record order, then the slot mapping of the mode
function automatic track_result_t expected_result(input int n, input key_mode_e km,
		input logic [7:0] ms, input logic tc);
	key_t top_key [NUM_COLORS][NUM_RANKS];
	int top_idx [NUM_COLORS][NUM_RANKS];
	track_result_t res;
	key_t key;
	int c;
	int r;
	top_key = '{default: '0};
	top_idx = '{default: 0};
	res = '0;
	for (int i = 0; i < n; i++) begin
		c = int'(rec_code[i]) - 1;
		key = (km == KEY_SIZE) ? rec_key[i][15:0] :
			(rec_key[i][23:16] > MAX_HEIGHT) ? 16'd0 : key_t'(rec_key[i][23:16]);
		if (c < 0 || c >= NUM_COLORS || key <= key_t'(ms))
			continue;
		r = NUM_RANKS;
		for (int k = NUM_RANKS - 1; k >= 0; k--)
			if (key > top_key[c][k])
				r = k; // Best rank the new key beats, ties stay below
		for (int k = NUM_RANKS - 1; k > r; k--) begin
			top_key[c][k] = top_key[c][k-1];
			top_idx[c][k] = top_idx[c][k-1];
		end
		if (r < NUM_RANKS) begin
			top_key[c][r] = key;
			top_idx[c][r] = i;
		end
	end
	for (int s = 0; s < NUM_SLOTS; s++) begin
		c = tc ? s / NUM_RANKS : s; // Two-color mode reads colors 0 and 1 only
		r = tc ? s % NUM_RANKS : 0;
		if (top_key[c][r] != '0)
			res.blob[s] = rec_cen[top_idx[c][r]];
	end
	return res;
endfunction

`endif

// ==== test/tb_blob_tracker.sv ====
`timescale 1ns/1ps

module tb_blob_tracker
	import blob_track_pkg::*, track_mem_pkg::*;
();

	localparam int NUM_COLORS = 6;
	localparam int NUM_RANKS = 3;
	// Six runs (one of 10 records and five of 30) at 4 + 2N + 12 cycles plus half again
	localparam int TIMEOUT_CYCLES = (6 * 16 + 2 * (10 + 5 * 30)) * 3 / 2;

	logic clk = 1'b0;
	logic rst_n;
	logic pause = 1'b0;
	logic pause_on = 1'b0; // Random pause pulses allowed
	logic enable;
	rec_idx_t blob_count;
	key_mode_e key_mode;
	logic [7:0] min_size;
	logic two_color;
	blob_word_u mem_data = '0;
	addr_t mem_addr;
	track_result_t result;
	logic done;
	logic done_q = 1'b0;

	logic [31:0] mem [2**18];
	logic [31:0] rec_cen [64];
	logic [7:0] rec_code [64];
	logic [31:0] rec_key [64];
	track_result_t expected;
	int fails = 0;
	int tests = 0;
	int runs_checked = 0;
	int cycle_cnt = 0;

	`include "tb_blob_model.svh"

	blob_tracker #(.NUM_COLORS(NUM_COLORS), .NUM_RANKS(NUM_RANKS)) uut (
		.clk(clk), .rst_n(rst_n), .pause(pause), .enable(enable), .blob_count(blob_count),
		.key_mode(key_mode), .min_size(min_size), .two_color(two_color),
		.mem_data(mem_data), .mem_addr(mem_addr), .result(result), .done(done)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (!pause)
			mem_data <= mem[mem_addr]; // One-cycle read that holds while paused
	end

	always @(posedge clk) begin
		pause <= pause_on && ($urandom_range(7) == 0);
		cycle_cnt <= cycle_cnt + 1;
	end

	// Compare on the first cycle of done
	always @(posedge clk) begin
		done_q <= done;
		if (done && !done_q) begin
			for (int s = 0; s < NUM_SLOTS; s++)
				check_value($sformatf("result.blob[%0d]", s), result.blob[s], expected.blob[s]);
			runs_checked++;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			fails++;
		end
	endtask

	task automatic run_test(input string name, input int n, input key_mode_e km,
			input logic [7:0] ms, input logic tc);
		int fails_before;
		int target;
		fails_before = fails;
		target = runs_checked + 1;
		expected = expected_result(n, km, ms, tc);
		@(posedge clk);
		blob_count <= rec_idx_t'(n);
		key_mode <= km;
		min_size <= ms;
		two_color <= tc;
		enable <= 1'b1;
		wait (runs_checked == target);
		pause_on <= 1'b0;
		@(posedge clk);
		enable <= 1'b0;
		repeat (2) @(posedge clk);
		check_value("done", 32'(done), 32'h0); // Idle again after enable falls
		tests++;
		$display("Test %0d %s: %s", tests, name, (fails == fails_before) ? "ok" : "mismatch");
	endtask

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("Timeout: the tracker did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'hdb16));
		foreach (mem[a])
			mem[a] = 32'(a) ^ 32'hc3a5_0000;
		rst_n = 1'b0;
		enable = 1'b0;
		blob_count = '0;
		key_mode = KEY_SIZE;
		min_size = '0;
		two_color = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_value("done", 32'(done), 32'h0);
		check_value("mem_addr", 32'(mem_addr), 32'h0);
		for (int s = 0; s < NUM_SLOTS; s++)
			check_value($sformatf("result.blob[%0d]", s), result.blob[s], 32'h0);
		tests++;
		$display("Test %0d reset values: %s", tests, (fails == 0) ? "ok" : "mismatch");
		load_records(10, 0, 0);
		run_test("no recognized color", 10, KEY_SIZE, 8'd0, 1'b0);
		load_records(30, 0, 8); // Codes above six name no color
		run_test("per-color size ranking", 30, KEY_SIZE, 8'd20, 1'b0);
		load_records(30, 0, 6);
		run_test("height ranking", 30, KEY_HEIGHT, 8'd50, 1'b0);
		load_records(30, 1, 2);
		run_test("two-color ranking", 30, KEY_SIZE, 8'd10, 1'b1);
		load_records(30, 0, 6);
		pause_on <= 1'b1;
		run_test("pause pulses", 30, KEY_SIZE, 8'd20, 1'b0);
		run_test("enable raised again", 30, KEY_SIZE, 8'd20, 1'b0); // Same records
		$display("%0d tests, %0d runs compared, %0d failures", tests, runs_checked, fails);
		if (fails == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+include
source/blob_track_pkg.sv
source/track_mem_pkg.sv
source/track_fsm.sv
source/record_counter.sv
source/rank_table.sv
source/centroid_collector.sv
source/blob_tracker.sv
test/tb_blob_tracker.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_blob_tracker
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR VFLAGS TOP FILELIST BUILD_DIR LOG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx '>>> PASS' $(LOG) || { echo "pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
